// File: rv_core_slice.f
hdl/rv_cfg_pkg.sv
hdl/rv_isa_pkg.sv
hdl/rf_rd_if.sv
hdl/rv_regfile.sv
hdl/rv_decoder.sv
hdl/pipe_reg.sv
hdl/rv_execute.sv
hdl/rv_core_slice.sv
verif/rv_core_slice_props.sv
verif/tb_rv_core_slice.sv

// File: run_sim.sh
#!/bin/sh
# build and run the rv_core_slice testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_rv_core_slice \
    -f rv_core_slice.f -o tb_sim

out=$(./obj_dir/tb_sim +verilator+error+limit+1000) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "TB PASSED"; then
    exit 0
fi
exit 1

// File: verif/tb_rv_core_slice.sv
module tb_rv_core_slice
    import rv_cfg_pkg::*;
    import rv_isa_pkg::*;
();

    typedef struct packed {
        logic                  wen;
        logic [reg_addr_w-1:0] addr;
        logic [xlen_w-1:0]     data;
        logic                  redirect;
        logic [xlen_w-1:0]     target;
        logic                  ebreak;
        logic                  illegal;
    } wb_exp_t;

    localparam int n_rand      = 64;
    localparam int stim_cycles = 16 + 60 + 2 * n_rand + 16; // reset, directed, random, drain
    localparam int timeout_t   = stim_cycles * 4 + 100;

    logic                  clk;
    logic                  rst_n;
    logic                  instr_valid_i;
    logic [instr_w-1:0]    instr_i;
    logic [xlen_w-1:0]     pc_i;
    logic                  stall_i;
    logic                  wb_en_o;
    logic [reg_addr_w-1:0] wb_addr_o;
    logic [xlen_w-1:0]     wb_data_o;
    logic                  redirect_o;
    logic [xlen_w-1:0]     redirect_pc_o;
    logic                  ebreak_o;
    logic                  illegal_o;

    logic [xlen_w-1:0] ref_regs [32]; // architectural register model
    logic [xlen_w-1:0] cur_pc;
    wb_exp_t           exp_q [$];
    wb_exp_t           head;
    int                errors = 0;

    rv_core_slice #(
        .reg_num (32)
    ) i_dut (.*);

    always #2 clk = ~clk;

    function automatic logic [31:0] addi_word(input logic [11:0] imm, input logic [4:0] rs1,
                                              input logic [4:0] rd);
        return {imm, rs1, f3_add_sub, rd, op_imm};
    endfunction

    function automatic logic [31:0] reg_word(input logic [6:0] f7, input logic [2:0] f3,
                                             input logic [4:0] rd, input logic [4:0] rs1,
                                             input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, op_reg};
    endfunction

    function automatic logic [31:0] lui_word(input logic [19:0] imm, input logic [4:0] rd);
        return {imm, rd, op_lui};
    endfunction

    function automatic logic [31:0] jal_word(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, op_jal};
    endfunction

    function automatic logic [31:0] branch_word(input logic [12:0] off, input logic [2:0] f3,
                                                input logic [4:0] rs1, input logic [4:0] rs2);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], op_branch};
    endfunction

    // expected outcome of one instruction in program order
    task automatic predict(input logic [31:0] ins);
        logic [xlen_w-1:0] a;
        logic [xlen_w-1:0] b;
        wb_exp_t           e;
        a      = ref_regs[ins[19:15]];
        b      = ref_regs[ins[24:20]];
        e      = '0;
        e.addr = ins[11:7];
        case (ins[6:0])
            op_imm: begin
                e.wen  = 1'b1;
                e.data = a + {{52{ins[31]}}, ins[31:20]};
            end
            op_lui: begin
                e.wen  = 1'b1;
                e.data = {{32{ins[31]}}, ins[31:12], 12'b0};
            end
            op_reg: begin
                e.wen = 1'b1;
                case ({ins[30], ins[14:12]})
                    4'b0000: e.data = a + b;
                    4'b1000: e.data = a - b;
                    4'b0111: e.data = a & b;
                    4'b0110: e.data = a | b;
                    4'b0100: e.data = a ^ b;
                    default: e.data = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0; // slt
                endcase
            end
            op_jal: begin
                e.wen      = 1'b1;
                e.data     = cur_pc + 64'd4;
                e.redirect = 1'b1;
                e.target   = cur_pc + {{44{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
            end
            op_branch: begin
                e.redirect = (a == b) != ins[12]; // funct3 bit 0 picks bne
                e.target   = cur_pc + {{52{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
            end
            op_system: e.ebreak = 1'b1;
            default:   e.illegal = 1'b1;
        endcase
        if (e.addr == 5'd0) begin
            e.wen = 1'b0;
        end
        if (e.wen) begin
            ref_regs[e.addr] = e.data;
        end
        if (e.wen || e.redirect || e.ebreak || e.illegal) begin
            exp_q.push_back(e);
        end
    endtask

    // offer one instruction, stalled for a few cycles first
    task automatic issue(input logic [31:0] ins, input int stall_cycles);
        instr_valid_i = 1'b1;
        instr_i       = ins;
        pc_i          = cur_pc;
        for (int i = 0; i < stall_cycles; i++) begin
            stall_i = 1'b1;
            @(posedge clk);
            #1;
        end
        stall_i = 1'b0;
        predict(ins);
        @(posedge clk);
        #1;
        instr_valid_i = 1'b0;
        cur_pc        = cur_pc + 64'd4;
    endtask

    task automatic idle(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    task automatic compare_value(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
        assert (got === exp) else begin
            errors++;
            $display("FAIL %s got %h expected %h", name, got, exp);
        end
    endtask

    always @(negedge clk) begin
        if (rst_n && (wb_en_o || redirect_o || ebreak_o || illegal_o)) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("DUT produced a result with no instruction pending at %0t", $time);
            end else begin
                head = exp_q.pop_front();
                compare_value("wb_en_o", 64'(wb_en_o), 64'(head.wen));
                if (head.wen) begin
                    compare_value("wb_addr_o", 64'(wb_addr_o), 64'(head.addr));
                    compare_value("wb_data_o", wb_data_o, head.data);
                end
                compare_value("redirect_o", 64'(redirect_o), 64'(head.redirect));
                if (head.redirect) begin
                    compare_value("redirect_pc_o", redirect_pc_o, head.target);
                end
                compare_value("ebreak_o", 64'(ebreak_o), 64'(head.ebreak));
                compare_value("illegal_o", 64'(illegal_o), 64'(head.illegal));
            end
        end
    end

    initial begin
        logic [11:0] r_imm;
        logic [4:0]  r_rd;
        int          missing;
        void'($urandom(32'h937bbf70));
        clk           = 1'b0;
        rst_n         = 1'b0;
        instr_valid_i = 1'b0;
        instr_i       = '0;
        pc_i          = '0;
        stall_i       = 1'b0;
        cur_pc        = 64'h1000;
        for (int i = 0; i < 32; i++) begin
            ref_regs[i] = '0;
        end
        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;

        issue(addi_word(12'd5, 5'd0, 5'd1), 0);
        issue(addi_word(12'hffd, 5'd0, 5'd2), 0);                     // -3
        issue(lui_word(20'h80000, 5'd3), 0);
        issue(addi_word(12'h7ff, 5'd3, 5'd4), 0);                     // forwarded lui
        issue(reg_word(f7_base, f3_add_sub, 5'd5, 5'd1, 5'd2), 0);
        issue(reg_word(f7_sub, f3_add_sub, 5'd6, 5'd5, 5'd1), 0);
        issue(reg_word(f7_base, f3_and, 5'd7, 5'd6, 5'd5), 0);        // x5 via write-through
        issue(reg_word(f7_base, f3_or, 5'd8, 5'd7, 5'd6), 0);
        issue(reg_word(f7_base, f3_xor, 5'd9, 5'd8, 5'd3), 0);
        issue(reg_word(f7_base, f3_slt, 5'd10, 5'd3, 5'd1), 0);
        issue(reg_word(f7_base, f3_slt, 5'd11, 5'd1, 5'd3), 0);
        idle(2);
        issue(addi_word(12'd7, 5'd1, 5'd0), 0);                       // dropped x0 write
        issue(reg_word(f7_base, f3_add_sub, 5'd12, 5'd0, 5'd0), 0);
        issue(reg_word(f7_base, f3_or, 5'd13, 5'd0, 5'd1), 0);
        issue(branch_word(13'd16, f3_beq, 5'd1, 5'd1), 0);            // taken
        issue(branch_word(13'd8, f3_bne, 5'd1, 5'd1), 0);             // not taken
        issue(branch_word(13'h1ff8, f3_bne, 5'd1, 5'd2), 0);          // taken, -8
        issue(branch_word(13'd12, f3_beq, 5'd1, 5'd2), 0);            // not taken
        issue(jal_word(21'h100, 5'd14), 0);
        issue(jal_word(21'h1fffec, 5'd0), 0);                         // -20, no link
        issue(reg_word(f7_base, f3_add_sub, 5'd15, 5'd14, 5'd14), 0);
        issue(32'h0010_0073, 0);                                      // ebreak
        issue(32'h0000_0000, 0);                                      // unknown opcode
        issue(addi_word(12'd1, 5'd1, 5'd16), 3);
        issue(reg_word(f7_base, f3_add_sub, 5'd17, 5'd16, 5'd16), 1);
        issue(reg_word(f7_sub, f3_add_sub, 5'd18, 5'd17, 5'd2), 0);
        idle(3);

        for (int i = 0; i < n_rand; i++) begin
            r_imm = 12'($urandom());
            r_rd  = 5'(1 + $urandom() % 31);
            issue(addi_word(r_imm, 5'd0, r_rd), ($urandom() % 4 == 0) ? 1 : 0);
        end

        for (int i = 0; i < 8 && exp_q.size() != 0; i++) begin
            @(posedge clk);
        end
        repeat (3) @(posedge clk);
        missing = exp_q.size();
        if (missing != 0) begin
            $display("%0d expected results never reached the DUT outputs", missing);
        end
        $display("errors: %0d compare, %0d assertion, %0d missing",
                 errors, i_dut.i_props.fail_cnt, missing);
        if (errors == 0 && i_dut.i_props.fail_cnt == 0 && missing == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    initial begin
        #(timeout_t);
        $display("watchdog expired after %0d time units", timeout_t);
        $display("TB FAILED");
        $finish;
    end

endmodule

// File: verif/rv_core_slice_props.sv
module rv_core_slice_props
    import rv_cfg_pkg::*;
(
    input logic                  clk,
    input logic                  rst_n,
    input logic                  instr_valid_i,
    input logic                  stall_i,
    input logic                  dec_wen_i,
    input logic [reg_addr_w-1:0] dec_rd_i,
    input logic                  dec_ebreak_i,
    input logic                  dec_illegal_i,
    input logic                  wb_en_i,
    input logic [reg_addr_w-1:0] wb_addr_i,
    input logic                  redirect_i,
    input logic                  ebreak_i,
    input logic                  illegal_i
);

    int unsigned fail_cnt = 0;
    logic        accept;
    logic        busy;

    assign accept = instr_valid_i && !stall_i; // instruction taken at this edge
    assign busy   = wb_en_i || redirect_i || ebreak_i || illegal_i;

    // nothing can reach the outputs in the first two edges after reset
    a_reset_quiet: assert property (@(posedge clk) $rose(rst_n) |-> !busy ##1 !busy)
        else begin
            fail_cnt++;
            $error("output flag active right after reset");
        end

    a_wb_latency: assert property (@(posedge clk) disable iff (!rst_n)
        accept && dec_wen_i |-> ##2 (wb_en_i && wb_addr_i == $past(dec_rd_i, 2)))
        else begin
            fail_cnt++;
            $error("write-back missing or wrong address two cycles after accept");
        end

    a_wb_source: assert property (@(posedge clk) disable iff (!rst_n)
        wb_en_i |-> $past(accept && dec_wen_i, 2))
        else begin
            fail_cnt++;
            $error("write-back pulse without a writing instruction two cycles earlier");
        end

    a_stall_bubble: assert property (@(posedge clk) disable iff (!rst_n)
        instr_valid_i && stall_i |-> ##2 !busy)
        else begin
            fail_cnt++;
            $error("stalled instruction reached the outputs");
        end

    a_trap_latency: assert property (@(posedge clk) disable iff (!rst_n)
        accept && (dec_ebreak_i || dec_illegal_i) |-> ##2
            (ebreak_i == $past(dec_ebreak_i, 2) && illegal_i == $past(dec_illegal_i, 2)
             && !wb_en_i))
        else begin
            fail_cnt++;
            $error("ebreak or illegal flag wrong two cycles after accept");
        end

endmodule

bind rv_core_slice rv_core_slice_props i_props (
    .clk           (clk),
    .rst_n         (rst_n),
    .instr_valid_i (instr_valid_i),
    .stall_i       (stall_i),
    .dec_wen_i     (dec_out.reg_wen),
    .dec_rd_i      (dec_out.rd),
    .dec_ebreak_i  (dec_out.ebreak),
    .dec_illegal_i (dec_out.illegal),
    .wb_en_i       (wb_en_o),
    .wb_addr_i     (wb_addr_o),
    .redirect_i    (redirect_o),
    .ebreak_i      (ebreak_o),
    .illegal_i     (illegal_o)
);

// File: hdl/rv_core_slice.sv
module rv_core_slice
    import rv_cfg_pkg::*;
    import rv_isa_pkg::*;
#(
    parameter int unsigned reg_num = rv_cfg_pkg::reg_num
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  instr_valid_i,
    input  logic [instr_w-1:0]    instr_i,
    input  logic [xlen_w-1:0]     pc_i,
    input  logic                  stall_i,
    output logic                  wb_en_o,
    output logic [reg_addr_w-1:0] wb_addr_o,
    output logic [xlen_w-1:0]     wb_data_o,
    output logic                  redirect_o,
    output logic [xlen_w-1:0]     redirect_pc_o,
    output logic                  ebreak_o,
    output logic                  illegal_o
);

    logic   dec_vld;
    id_ex_t dec_out;
    logic   id_ex_vld;
    id_ex_t id_ex_q;
    logic   ex_vld;
    ex_wb_t ex_out;
    logic   ex_wb_vld;
    ex_wb_t ex_wb_q;

    rf_rd_if i_rf_rd ();

    rv_decoder i_decoder (
        .instr_i (instr_i),
        .pc_i    (pc_i),
        .valid_i (instr_valid_i),
        .rd      (i_rf_rd.reader),
        .valid_o (dec_vld),
        .id_ex_o (dec_out)
    );

    rv_regfile #(
        .reg_num (reg_num)
    ) i_regfile (
        .clk     (clk),
        .rst_n   (rst_n),
        .rd      (i_rf_rd.file),
        .wen_i   (wb_en_o),
        .waddr_i (ex_wb_q.rd),
        .wdata_i (ex_wb_q.result)
    );

    pipe_reg #(
        .payload_t (id_ex_t)
    ) i_id_ex (
        .clk     (clk),
        .rst_n   (rst_n),
        .hold_i  (stall_i),
        .valid_i (dec_vld),
        .data_i  (dec_out),
        .valid_o (id_ex_vld),
        .data_o  (id_ex_q)
    );

    rv_execute i_execute (
        .valid_i     (id_ex_vld),
        .id_ex_i     (id_ex_q),
        .fwd_valid_i (ex_wb_vld),
        .fwd_i       (ex_wb_q),
        .valid_o     (ex_vld),
        .ex_wb_o     (ex_out)
    );

    pipe_reg #(
        .payload_t (ex_wb_t)
    ) i_ex_wb (
        .clk     (clk),
        .rst_n   (rst_n),
        .hold_i  (1'b0), // no back-pressure after execute
        .valid_i (ex_vld),
        .data_i  (ex_out),
        .valid_o (ex_wb_vld),
        .data_o  (ex_wb_q)
    );

    // flags qualified by the stage valid, payload goes out raw
    assign wb_en_o       = ex_wb_vld && ex_wb_q.reg_wen;
    assign wb_addr_o     = ex_wb_q.rd;
    assign wb_data_o     = ex_wb_q.result;
    assign redirect_o    = ex_wb_vld && ex_wb_q.redirect;
    assign redirect_pc_o = ex_wb_q.redirect_pc;
    assign ebreak_o      = ex_wb_vld && ex_wb_q.ebreak;
    assign illegal_o     = ex_wb_vld && ex_wb_q.illegal;

endmodule

// File: hdl/rv_execute.sv
module rv_execute
    import rv_cfg_pkg::*;
    import rv_isa_pkg::*;
(
    input  logic   valid_i,
    input  id_ex_t id_ex_i,
    input  logic   fwd_valid_i,
    input  ex_wb_t fwd_i,
    output logic   valid_o,
    output ex_wb_t ex_wb_o
);

    logic [xlen_w-1:0] op_a;
    logic [xlen_w-1:0] rs2_val;
    logic [xlen_w-1:0] op_b;
    logic [xlen_w-1:0] alu_res;
    logic              taken;

    // result of the instruction one ahead, not yet in the register file
    function automatic logic [xlen_w-1:0] fwd_sel(input logic [reg_addr_w-1:0] addr,
                                                  input logic [xlen_w-1:0]     data);
        logic hit;
        hit = fwd_valid_i && fwd_i.reg_wen && (addr != '0) && (fwd_i.rd == addr);
        return hit ? fwd_i.result : data;
    endfunction

    assign op_a    = fwd_sel(id_ex_i.rs1_addr, id_ex_i.rs1_data);
    assign rs2_val = fwd_sel(id_ex_i.rs2_addr, id_ex_i.rs2_data);
    assign op_b    = (id_ex_i.src_b == src_b_imm) ? id_ex_i.imm : rs2_val;

    always_comb begin
        case (id_ex_i.alu_op)
            alu_add:    alu_res = op_a + op_b;
            alu_sub:    alu_res = op_a - op_b;
            alu_and:    alu_res = op_a & op_b;
            alu_or:     alu_res = op_a | op_b;
            alu_xor:    alu_res = op_a ^ op_b;
            alu_slt:    alu_res = {{(xlen_w-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            alu_pass_b: alu_res = op_b;
            default:    alu_res = '0;
        endcase
    end

    // beq takes on equal, bne on unequal
    assign taken = id_ex_i.branch && ((op_a == rs2_val) != id_ex_i.branch_ne);

    always_comb begin
        ex_wb_o.result      = alu_res;
        ex_wb_o.rd          = id_ex_i.rd;
        ex_wb_o.reg_wen     = id_ex_i.reg_wen;
        ex_wb_o.redirect    = taken || id_ex_i.jump;
        ex_wb_o.redirect_pc = id_ex_i.pc + id_ex_i.imm; // same target for branch and jal
        ex_wb_o.ebreak      = id_ex_i.ebreak;
        ex_wb_o.illegal     = id_ex_i.illegal;
    end

    assign valid_o = valid_i;

endmodule

// File: hdl/pipe_reg.sv
module pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     hold_i,
    input  logic     valid_i,
    input  payload_t data_i,
    output logic     valid_o,
    output payload_t data_o
);

    // a held slot drops its valid so nothing issues twice
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= valid_i && !hold_i; // bubble on hold
        end
    end

    always_ff @(posedge clk) begin
        if (!hold_i) begin
            data_o <= data_i; // payload kept while held
        end
    end

endmodule

// File: hdl/rv_decoder.sv
module rv_decoder
    import rv_cfg_pkg::*;
    import rv_isa_pkg::*;
(
    input  logic [instr_w-1:0] instr_i,
    input  logic [xlen_w-1:0]  pc_i,
    input  logic               valid_i,
    rf_rd_if.reader            rd,
    output logic               valid_o,
    output id_ex_t             id_ex_o
);

    logic [6:0]            opcode;
    logic [2:0]            funct3;
    logic [6:0]            funct7;
    logic [reg_addr_w-1:0] rd_f;
    logic [xlen_w-1:0]     imm_i;
    logic [xlen_w-1:0]     imm_u;
    logic [xlen_w-1:0]     imm_j;
    logic [xlen_w-1:0]     imm_b;
    logic                  use_rs1;
    logic                  use_rs2;
    logic                  wen_raw;
    id_ex_t                ctrl;

    assign opcode = instr_i[6:0];
    assign rd_f   = instr_i[11:7];
    assign funct3 = instr_i[14:12];
    assign funct7 = instr_i[31:25];

    assign imm_i = {{(xlen_w-12){instr_i[31]}}, instr_i[31:20]};
    assign imm_u = {{(xlen_w-32){instr_i[31]}}, instr_i[31:12], 12'b0};
    assign imm_j = {{(xlen_w-20){instr_i[31]}}, instr_i[19:12], instr_i[20],
                    instr_i[30:21], 1'b0};
    assign imm_b = {{(xlen_w-12){instr_i[31]}}, instr_i[7], instr_i[30:25],
                    instr_i[11:8], 1'b0};

    always_comb begin
        ctrl        = '0;
        ctrl.pc     = pc_i;
        ctrl.alu_op = alu_add;
        ctrl.src_b  = src_b_reg;
        ctrl.rd     = rd_f;
        use_rs1     = 1'b0;
        use_rs2     = 1'b0;
        wen_raw     = 1'b0;
        case (opcode)
            op_imm: begin
                if (funct3 == f3_add_sub) begin // addi only
                    use_rs1    = 1'b1;
                    ctrl.imm   = imm_i;
                    ctrl.src_b = src_b_imm;
                    wen_raw    = 1'b1;
                end else begin
                    ctrl.illegal = 1'b1;
                end
            end
            op_reg: begin
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
                wen_raw = 1'b1;
                case ({funct7, funct3})
                    {f7_base, f3_add_sub}: ctrl.alu_op = alu_add;
                    {f7_sub, f3_add_sub}:  ctrl.alu_op = alu_sub;
                    {f7_base, f3_slt}:     ctrl.alu_op = alu_slt;
                    {f7_base, f3_xor}:     ctrl.alu_op = alu_xor;
                    {f7_base, f3_or}:      ctrl.alu_op = alu_or;
                    {f7_base, f3_and}:     ctrl.alu_op = alu_and;
                    default: begin
                        ctrl.illegal = 1'b1;
                        wen_raw      = 1'b0;
                    end
                endcase
            end
            op_lui: begin
                ctrl.imm    = imm_u;
                ctrl.src_b  = src_b_imm;
                ctrl.alu_op = alu_pass_b;
                wen_raw     = 1'b1;
            end
            op_jal: begin
                ctrl.imm  = imm_j; // target offset, link value built below
                ctrl.jump = 1'b1;
                wen_raw   = 1'b1;
            end
            op_branch: begin
                if (funct3 == f3_beq || funct3 == f3_bne) begin
                    use_rs1        = 1'b1;
                    use_rs2        = 1'b1;
                    ctrl.imm       = imm_b;
                    ctrl.branch    = 1'b1;
                    ctrl.branch_ne = (funct3 == f3_bne);
                end else begin
                    ctrl.illegal = 1'b1;
                end
            end
            op_system: begin
                ctrl.ebreak  = (instr_i == instr_ebreak);
                ctrl.illegal = (instr_i != instr_ebreak);
            end
            default: ctrl.illegal = 1'b1;
        endcase
        // unused source fields are zeroed so they never match a forward
        ctrl.rs1_addr = use_rs1 ? instr_i[19:15] : '0;
        ctrl.rs2_addr = use_rs2 ? instr_i[24:20] : '0;
        ctrl.reg_wen  = wen_raw && (rd_f != '0) && !ctrl.branch;
    end

    assign rd.rs1_addr = ctrl.rs1_addr;
    assign rd.rs2_addr = ctrl.rs2_addr;

    // jal links through the adder as pc + 4
    always_comb begin
        id_ex_o          = ctrl;
        id_ex_o.rs1_data = ctrl.jump ? pc_i : rd.rs1_data;
        id_ex_o.rs2_data = ctrl.jump ? xlen_w'(4) : rd.rs2_data;
    end

    assign valid_o = valid_i;

endmodule

// File: hdl/rv_regfile.sv
module rv_regfile
    import rv_cfg_pkg::*;
#(
    parameter int unsigned reg_num = rv_cfg_pkg::reg_num
) (
    input  logic                  clk,
    input  logic                  rst_n,
    rf_rd_if.file                 rd,
    input  logic                  wen_i,
    input  logic [reg_addr_w-1:0] waddr_i,
    input  logic [xlen_w-1:0]     wdata_i
);

    logic [xlen_w-1:0] regs [reg_num];
    logic              wr_act;

    assign wr_act = wen_i && (waddr_i != '0); // x0 never written

    // a write landing this cycle is visible to decode right away
    function automatic logic [xlen_w-1:0] read_port(input logic [reg_addr_w-1:0] addr);
        logic [xlen_w-1:0] val;
        val = regs[addr];
        if (wr_act && (waddr_i == addr)) begin
            val = wdata_i;
        end
        return val;
    endfunction

    always_comb begin
        rd.rs1_data = read_port(rd.rs1_addr);
        rd.rs2_data = read_port(rd.rs2_addr);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < reg_num; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_act) begin
            regs[waddr_i] <= wdata_i;
        end
    end

endmodule

// File: hdl/rf_rd_if.sv
interface rf_rd_if
    import rv_cfg_pkg::*;
();

    logic [reg_addr_w-1:0] rs1_addr;
    logic [reg_addr_w-1:0] rs2_addr;
    logic [xlen_w-1:0]     rs1_data;
    logic [xlen_w-1:0]     rs2_data;

    // decode side drives the addresses
    modport reader (
        output rs1_addr,
        output rs2_addr,
        input  rs1_data,
        input  rs2_data
    );

    // register file answers combinationally
    modport file (
        input  rs1_addr,
        input  rs2_addr,
        output rs1_data,
        output rs2_data
    );

endinterface

// File: hdl/rv_isa_pkg.sv
package rv_isa_pkg;
    import rv_cfg_pkg::*;

    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_reg    = 7'b0110011;
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_system = 7'b1110011;

    localparam logic [2:0] f3_add_sub = 3'b000; // also addi
    localparam logic [2:0] f3_slt     = 3'b010;
    localparam logic [2:0] f3_xor     = 3'b100;
    localparam logic [2:0] f3_or      = 3'b110;
    localparam logic [2:0] f3_and     = 3'b111;
    localparam logic [2:0] f3_beq     = 3'b000;
    localparam logic [2:0] f3_bne     = 3'b001;

    localparam logic [6:0] f7_base = 7'b0000000;
    localparam logic [6:0] f7_sub  = 7'b0100000;

    localparam logic [instr_w-1:0] instr_ebreak = 32'h0010_0073; // only legal system encoding

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_pass_b
    } alu_op_e;

    typedef enum logic {
        src_b_reg,
        src_b_imm
    } src_b_e;

    typedef struct packed {
        logic [xlen_w-1:0]     pc;
        logic [reg_addr_w-1:0] rs1_addr;
        logic [reg_addr_w-1:0] rs2_addr;
        logic [xlen_w-1:0]     rs1_data;
        logic [xlen_w-1:0]     rs2_data;
        logic [xlen_w-1:0]     imm;
        alu_op_e               alu_op;
        src_b_e                src_b;
        logic [reg_addr_w-1:0] rd;
        logic                  reg_wen;
        logic                  branch;
        logic                  branch_ne; // bne when set, beq otherwise
        logic                  jump;
        logic                  ebreak;
        logic                  illegal;
    } id_ex_t;

    typedef struct packed {
        logic [xlen_w-1:0]     result;
        logic [reg_addr_w-1:0] rd;
        logic                  reg_wen;
        logic                  redirect;
        logic [xlen_w-1:0]     redirect_pc;
        logic                  ebreak;
        logic                  illegal;
    } ex_wb_t;

endpackage

// File: hdl/rv_cfg_pkg.sv
package rv_cfg_pkg;

    // datapath width of the integer core
    localparam int unsigned xlen_w = 64;

    // instruction word as fetched
    localparam int unsigned instr_w = 32;

    // register file geometry
    localparam int unsigned reg_addr_w = 5;
    localparam int unsigned reg_num    = 32;

endpackage
